/* sources.f */
pipeline_pkg.sv
pipe_reg.sv
gpr.sv
decoder.sv
forward_unit.sv
exec_unit.sv
pipeline.sv
tb_pipeline.sv

/* run.sh */
#!/bin/bash
# Build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_pipeline -f sources.f \
    -o sim_tb_pipeline && ./obj_dir/sim_tb_pipeline > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "^PASS: all tests$" sim.log && echo "Result: passed" || { echo "Result: failed"; exit 1; }

/* tb_pipeline.sv */
`timescale 1ns/1ps

module tb_pipeline;

    localparam int reset_cycles = 5;
    localparam int random_count = 48;

    // SPECIAL function codes used by the random stream
    localparam logic [5:0] r_functs [18] = '{
        6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h0a, 6'h0b, 6'h20,
        6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b
    };

    // One program entry with the write-back it should produce
    typedef struct packed {
        logic [31:0] instr;
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } step_t;

    logic        clk;
    logic        reset;
    logic [31:0] instr_addr;
    logic [31:0] instr_data;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    step_t       steps[$];
    logic [31:0] model_regs [32];
    logic [31:0] lcg_state;
    int          cycle_count;
    int          cycle_limit;
    logic        counting;

    pipeline #(.reset_pc(32'h0)) dut (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .instr_addr ( instr_addr ),
        .instr_data ( instr_data ),
        .wb_en      ( wb_en      ),
        .wb_addr    ( wb_addr    ),
        .wb_data    ( wb_data    )
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Encoding and stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] r_format(input logic [5:0] fn, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd,
                                             input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_format(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Registers 1 to 7 only to keep dependencies dense
    function automatic logic [4:0] pick_reg(input logic [31:0] v);
        return 5'(v % 32'd7 + 32'd1);
    endfunction

    // Instruction memory reads zero past the end of the program
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr[31:2]);
        if (idx < steps.size()) begin
            return steps[idx].instr;
        end
        return 32'h0;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    task automatic model_step(input logic [31:0] instr);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  sh;
        logic [4:0]  dst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] res;
        logic        ok;
        longint      wide;
        step_t       s;
        op   = instr[31:26];
        fn   = instr[5:0];
        rs   = instr[25:21];
        rt   = instr[20:16];
        sh   = instr[10:6];
        a    = model_regs[rs];
        b    = model_regs[rt];
        sext = {{16{instr[15]}}, instr[15:0]};
        zext = {16'h0000, instr[15:0]};
        dst  = (op == 6'h00) ? instr[15:11] : rt;
        res  = 32'h0;
        ok   = 1'b1;
        if (op == 6'h00) begin
            case (fn)
                6'h00: res = b << sh;
                6'h02: res = b >> sh;
                6'h03: res = $signed(b) >>> sh;
                6'h04: res = b << a[4:0];
                6'h06: res = b >> a[4:0];
                6'h07: res = $signed(b) >>> a[4:0];
                6'h0a: begin
                    res = a;
                    ok  = (b == 32'h0);
                end
                6'h0b: begin
                    res = a;
                    ok  = (b != 32'h0);
                end
                6'h20: begin
                    wide = longint'($signed(a)) + longint'($signed(b));
                    res  = wide[31:0];
                    ok   = (wide == longint'($signed(res)));
                end
                6'h21: res = a + b;
                6'h22: begin
                    wide = longint'($signed(a)) - longint'($signed(b));
                    res  = wide[31:0];
                    ok   = (wide == longint'($signed(res)));
                end
                6'h23: res = a - b;
                6'h24: res = a & b;
                6'h25: res = a | b;
                6'h26: res = a ^ b;
                6'h27: res = ~(a | b);
                6'h2a: res = {31'h0, $signed(a) < $signed(b)};
                6'h2b: res = {31'h0, a < b};
                default: ok = 1'b0;
            endcase
        end else begin
            case (op)
                6'h08: begin
                    wide = longint'($signed(a)) + longint'($signed(sext));
                    res  = wide[31:0];
                    ok   = (wide == longint'($signed(res)));
                end
                6'h09: res = a + sext;
                6'h0a: res = {31'h0, $signed(a) < $signed(sext)};
                6'h0b: res = {31'h0, a < sext};
                6'h0c: res = a & zext;
                6'h0d: res = a | zext;
                6'h0e: res = a ^ zext;
                6'h0f: res = {instr[15:0], 16'h0000};
                default: ok = 1'b0;
            endcase
        end
        ok = ok && (dst != 5'd0);
        if (ok) begin
            model_regs[dst] = res;
        end
        s.instr = instr;
        s.en    = ok;
        s.addr  = dst;
        s.data  = res;
        steps.push_back(s);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Programs
    //////////////////////////////////////////////////////////////////////

    task automatic directed_program();
        // Immediates and extension
        model_step(i_format(6'h0d, 5'd0, 5'd1, 16'h1234));    // ori   $1, $0, 0x1234
        model_step(i_format(6'h0f, 5'd0, 5'd2, 16'h8000));    // lui   $2, 0x8000
        model_step(i_format(6'h09, 5'd0, 5'd3, 16'hffff));    // addiu $3, $0, -1
        model_step(i_format(6'h0d, 5'd0, 5'd4, 16'hffff));    // ori   $4, $0, 0xffff
        model_step(i_format(6'h0c, 5'd3, 5'd5, 16'h8001));    // andi  $5, $3, 0x8001
        model_step(i_format(6'h0e, 5'd3, 5'd6, 16'hf0f0));    // xori  $6, $3, 0xf0f0
        // Register ALU ops with distance 1 and 2 dependencies
        model_step(r_format(6'h21, 5'd1, 5'd4, 5'd7, 5'd0));  // addu  $7, $1, $4
        model_step(r_format(6'h23, 5'd0, 5'd7, 5'd8, 5'd0));  // subu  $8, $0, $7
        model_step(r_format(6'h24, 5'd3, 5'd1, 5'd9, 5'd0));  // and
        model_step(r_format(6'h25, 5'd2, 5'd8, 5'd10, 5'd0)); // or
        model_step(r_format(6'h26, 5'd3, 5'd2, 5'd11, 5'd0)); // xor
        model_step(r_format(6'h27, 5'd0, 5'd0, 5'd12, 5'd0)); // nor
        // Signed versus unsigned compares
        model_step(r_format(6'h2a, 5'd2, 5'd1, 5'd13, 5'd0));
        model_step(r_format(6'h2b, 5'd2, 5'd1, 5'd14, 5'd0));
        model_step(i_format(6'h0a, 5'd3, 5'd15, 16'h0000));
        model_step(i_format(6'h0b, 5'd1, 5'd16, 16'hffff));
        model_step(i_format(6'h0a, 5'd1, 5'd17, 16'h8000));
        // Constant and variable shifts
        model_step(r_format(6'h00, 5'd0, 5'd1, 5'd18, 5'd4));
        model_step(r_format(6'h02, 5'd0, 5'd2, 5'd19, 5'd31));
        model_step(r_format(6'h03, 5'd0, 5'd2, 5'd20, 5'd4));
        model_step(r_format(6'h03, 5'd0, 5'd2, 5'd21, 5'd0));
        model_step(r_format(6'h00, 5'd0, 5'd3, 5'd22, 5'd31));
        model_step(i_format(6'h0d, 5'd0, 5'd23, 16'h001f));
        model_step(r_format(6'h07, 5'd23, 5'd2, 5'd24, 5'd0)); // srav by 31
        model_step(r_format(6'h04, 5'd23, 5'd1, 5'd25, 5'd0));
        model_step(r_format(6'h06, 5'd1, 5'd2, 5'd26, 5'd0));
        model_step(r_format(6'h03, 5'd0, 5'd6, 5'd26, 5'd0));
        // Overflow suppression leaves $28 at 5
        model_step(i_format(6'h0f, 5'd0, 5'd27, 16'h7fff));
        model_step(i_format(6'h0d, 5'd27, 5'd27, 16'hffff));
        model_step(i_format(6'h0d, 5'd0, 5'd28, 16'h0005));
        model_step(r_format(6'h20, 5'd27, 5'd27, 5'd28, 5'd0));
        model_step(r_format(6'h21, 5'd28, 5'd0, 5'd29, 5'd0));
        model_step(r_format(6'h21, 5'd27, 5'd27, 5'd29, 5'd0));
        model_step(r_format(6'h22, 5'd2, 5'd1, 5'd28, 5'd0));
        model_step(i_format(6'h08, 5'd27, 5'd28, 16'h0001));
        model_step(r_format(6'h21, 5'd28, 5'd0, 5'd30, 5'd0));
        // Conditional moves
        model_step(r_format(6'h0a, 5'd1, 5'd0, 5'd9, 5'd0));
        model_step(r_format(6'h0a, 5'd1, 5'd3, 5'd10, 5'd0));
        model_step(r_format(6'h0b, 5'd1, 5'd3, 5'd11, 5'd0));
        model_step(r_format(6'h0b, 5'd1, 5'd0, 5'd12, 5'd0));
        model_step(r_format(6'h21, 5'd10, 5'd12, 5'd31, 5'd0));
        // Writes to $0 are dropped
        model_step(i_format(6'h09, 5'd1, 5'd0, 16'h0005));
        model_step(r_format(6'h21, 5'd0, 5'd0, 5'd5, 5'd0));
    endtask

    task automatic random_program();
        logic [31:0] r;
        logic [31:0] r2;
        int          k;
        for (int n = 0; n < random_count; n++) begin
            r  = lcg_next();
            r2 = lcg_next();
            if (r2[30]) begin
                k = int'(r[31:27]) % 18;
                model_step(r_format(r_functs[k], pick_reg(r >> 8), pick_reg(r >> 14),
                                    pick_reg(r >> 20), r2[15:11]));
            end else begin
                model_step(i_format(6'h08 | {3'b000, r[31:29]}, pick_reg(r >> 8),
                                    pick_reg(r >> 14), r2[31:16]));
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // Negative or past-the-end index means a bubble
    task automatic expect_writeback(input int idx);
        step_t s;
        s = '0;
        if (idx >= 0 && idx < steps.size()) begin
            s = steps[idx];
        end
        check_value("wb_en", {31'h0, s.en}, {31'h0, wb_en});
        if (s.en) begin
            check_value("wb_addr", {27'h0, s.addr}, {27'h0, wb_addr});
            check_value("wb_data", s.data, wb_data);
        end
    endtask

    always @(posedge clk) begin
        if (counting) begin
            cycle_count = cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                $display("Timeout: no end of run within %0d cycles after reset", cycle_limit);
                $display("FAIL: see errors above");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        int fall;
        clk         = 1'b0;
        reset       = 1'b1;
        instr_data  = 32'h0;
        lcg_state   = 32'hd226_7a95;
        cycle_count = 0;
        counting    = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        directed_program();
        random_program();
        cycle_limit = steps.size() + 20;

        repeat (reset_cycles - 1) begin
            @(negedge clk);
            check_value("wb_en", 32'h0, {31'h0, wb_en});
        end
        // Fall 0 releases reset and instruction f is fetched at fall f
        for (fall = 0; fall <= steps.size() + 3; fall++) begin
            @(negedge clk);
            reset    = 1'b0;
            counting = 1'b1;
            expect_writeback(fall - 3);
            check_value("instr_addr", 32'(fall * 4), instr_addr);
            instr_data = fetch_word(instr_addr);
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* pipeline.sv */
`timescale 1ns/1ps

module pipeline #(
    parameter pipeline_pkg::word_t reset_pc = '0
) (
    input  logic                    clk,
    input  logic                    reset,
    output pipeline_pkg::word_t     instr_addr,
    input  pipeline_pkg::word_t     instr_data,
    output logic                    wb_en,
    output pipeline_pkg::reg_addr_t wb_addr,
    output pipeline_pkg::word_t     wb_data
);

    pipeline_pkg::word_t       pc;
    logic                      fetch_valid;
    pipeline_pkg::if_id_t      if_id_in;
    pipeline_pkg::if_id_t      if_id_q;
    logic                      id_valid;
    wire pipeline_pkg::id_ex_t id_ex_in;
    pipeline_pkg::id_ex_t      id_ex_q;
    logic                      ex_valid;
    pipeline_pkg::word_t       op_a;
    pipeline_pkg::word_t       op_b;
    pipeline_pkg::ex_wb_t      ex_wb_in;
    pipeline_pkg::ex_wb_t      ex_wb_q;
    logic                      wb_valid;

    //////////////////////////////////////////////////////////////////////
    // IF
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else begin
            pc <= pc + pipeline_pkg::word_t'(4);
        end
    end

    // Fetch is live from the first cycle out of reset
    assign fetch_valid    = !reset;
    assign instr_addr     = pc;
    assign if_id_in.instr = instr_data;

    pipe_reg #(.payload_t(pipeline_pkg::if_id_t)) if_id (
        .clk       ( clk         ),
        .reset     ( reset       ),
        .valid_in  ( fetch_valid ),
        .data_in   ( if_id_in    ),
        .valid_out ( id_valid    ),
        .data_out  ( if_id_q     )
    );

    //////////////////////////////////////////////////////////////////////
    // ID
    //////////////////////////////////////////////////////////////////////

    decoder decoder (
        .instr          ( if_id_q.instr           ),
        .valid          ( id_valid                ),
        .rs_addr        ( id_ex_in.rs_addr        ),
        .rt_addr        ( id_ex_in.rt_addr        ),
        .dst_addr       ( id_ex_in.dst_addr       ),
        .imm            ( id_ex_in.imm            ),
        .shamt          ( id_ex_in.shamt          ),
        .alu_op         ( id_ex_in.alu_op         ),
        .shift_op       ( id_ex_in.shift_op       ),
        .res_sel        ( id_ex_in.res_sel        ),
        .b_is_imm       ( id_ex_in.b_is_imm       ),
        .shamt_from_reg ( id_ex_in.shamt_from_reg ),
        .reg_w          ( id_ex_in.reg_w          ),
        .of_w_disable   ( id_ex_in.of_w_disable   ),
        .movz           ( id_ex_in.movz           ),
        .movn           ( id_ex_in.movn           )
    );

    // Written from the WB register, read here in ID
    gpr gpr (
        .clk     ( clk              ),
        .reset   ( reset            ),
        .rs_addr ( id_ex_in.rs_addr ),
        .rt_addr ( id_ex_in.rt_addr ),
        .rs_data ( id_ex_in.rs_data ),
        .rt_data ( id_ex_in.rt_data ),
        .w_en    ( wb_en            ),
        .w_addr  ( wb_addr          ),
        .w_data  ( wb_data          )
    );

    pipe_reg #(.payload_t(pipeline_pkg::id_ex_t)) id_ex (
        .clk       ( clk      ),
        .reset     ( reset    ),
        .valid_in  ( id_valid ),
        .data_in   ( id_ex_in ),
        .valid_out ( ex_valid ),
        .data_out  ( id_ex_q  )
    );

    //////////////////////////////////////////////////////////////////////
    // EX
    //////////////////////////////////////////////////////////////////////

    forward_unit forward_unit (
        .rs_addr ( id_ex_q.rs_addr ),
        .rt_addr ( id_ex_q.rt_addr ),
        .rs_data ( id_ex_q.rs_data ),
        .rt_data ( id_ex_q.rt_data ),
        .wb_en   ( wb_en           ),
        .wb_addr ( wb_addr         ),
        .wb_data ( wb_data         ),
        .op_a    ( op_a            ),
        .op_b    ( op_b            )
    );

    exec_unit exec_unit (
        .ctrl   ( id_ex_q  ),
        .valid  ( ex_valid ),
        .op_a   ( op_a     ),
        .op_b   ( op_b     ),
        .result ( ex_wb_in )
    );

    pipe_reg #(.payload_t(pipeline_pkg::ex_wb_t)) ex_wb (
        .clk       ( clk      ),
        .reset     ( reset    ),
        .valid_in  ( ex_valid ),
        .data_in   ( ex_wb_in ),
        .valid_out ( wb_valid ),
        .data_out  ( ex_wb_q  )
    );

    //////////////////////////////////////////////////////////////////////
    // WB
    //////////////////////////////////////////////////////////////////////

    // Payload is not reset, so qualify with the stage valid
    assign wb_en   = wb_valid && ex_wb_q.w_en;
    assign wb_addr = ex_wb_q.dst_addr;
    assign wb_data = ex_wb_q.result;

endmodule

/* exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  pipeline_pkg::id_ex_t ctrl,
    input  logic                 valid,
    input  pipeline_pkg::word_t  op_a,
    input  pipeline_pkg::word_t  op_b,
    output pipeline_pkg::ex_wb_t result
);

    localparam int msb = pipeline_pkg::data_width - 1;

    pipeline_pkg::word_t          alu_b;
    pipeline_pkg::word_t          sum;
    logic [pipeline_pkg::data_width:0] diff;
    pipeline_pkg::word_t          alu_res;
    pipeline_pkg::word_t          shift_res;
    logic [4:0]                   shamt;
    logic                         add_ovf;
    logic                         sub_ovf;
    logic                         less;
    logic                         overflow;
    logic                         rt_zero;

    //////////////////////////////////////////////////////////////////////
    // Operand selection
    //////////////////////////////////////////////////////////////////////

    // Conditional moves pass rs through the adder unchanged
    assign alu_b = (ctrl.movz || ctrl.movn) ? '0 : (ctrl.b_is_imm ? ctrl.imm : op_b);
    assign shamt = ctrl.shamt_from_reg ? op_a[4:0] : ctrl.shamt;

    //////////////////////////////////////////////////////////////////////
    // ALU and flags
    //////////////////////////////////////////////////////////////////////

    assign sum  = op_a + alu_b;
    assign diff = {1'b0, op_a} - {1'b0, alu_b};

    assign add_ovf = (op_a[msb] == alu_b[msb]) && (sum[msb] != op_a[msb]);
    assign sub_ovf = (op_a[msb] != alu_b[msb]) && (diff[msb] != op_a[msb]);

    // Borrow out gives the unsigned compare
    assign less = (ctrl.alu_op == pipeline_pkg::alu_sltu) ? diff[msb+1] : (diff[msb] ^ sub_ovf);

    assign overflow = ((ctrl.alu_op == pipeline_pkg::alu_add) && add_ovf)
                   || ((ctrl.alu_op == pipeline_pkg::alu_sub) && sub_ovf);

    // Condition operand for MOVZ/MOVN
    assign rt_zero = (op_b == '0);

    always_comb begin
        case (ctrl.alu_op)
            pipeline_pkg::alu_sub:  alu_res = diff[msb:0];
            pipeline_pkg::alu_and:  alu_res = op_a & alu_b;
            pipeline_pkg::alu_or:   alu_res = op_a | alu_b;
            pipeline_pkg::alu_xor:  alu_res = op_a ^ alu_b;
            pipeline_pkg::alu_nor:  alu_res = ~(op_a | alu_b);
            pipeline_pkg::alu_slt,
            pipeline_pkg::alu_sltu: alu_res = pipeline_pkg::word_t'(less);
            pipeline_pkg::alu_lui:  alu_res = alu_b;
            default:                alu_res = sum;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Shifter
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.shift_op)
            pipeline_pkg::sh_srl: shift_res = op_b >> shamt;
            pipeline_pkg::sh_sra: shift_res = pipeline_pkg::word_t'($signed(op_b) >>> shamt);
            default:              shift_res = op_b << shamt;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Result and write enable
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        result.dst_addr = ctrl.dst_addr;
        result.result   = (ctrl.res_sel == pipeline_pkg::res_shift) ? shift_res : alu_res;
        result.w_en     = valid
                       && ctrl.reg_w
                       && (ctrl.dst_addr != '0)
                       && !(overflow && ctrl.of_w_disable)
                       && !(ctrl.movz && !rt_zero)
                       && !(ctrl.movn && rt_zero);
    end

endmodule

/* forward_unit.sv */
`timescale 1ns/1ps

module forward_unit (
    input  pipeline_pkg::reg_addr_t rs_addr,
    input  pipeline_pkg::reg_addr_t rt_addr,
    input  pipeline_pkg::word_t     rs_data,
    input  pipeline_pkg::word_t     rt_data,
    input  logic                    wb_en,
    input  pipeline_pkg::reg_addr_t wb_addr,
    input  pipeline_pkg::word_t     wb_data,
    output pipeline_pkg::word_t     op_a,
    output pipeline_pkg::word_t     op_b
);

    logic hit_a;
    logic hit_b;

    // wb_en is never high for $0
    assign hit_a = wb_en && (wb_addr == rs_addr);
    assign hit_b = wb_en && (wb_addr == rt_addr);

    // Result one stage ahead wins over the decode-time read
    assign op_a = hit_a ? wb_data : rs_data;
    assign op_b = hit_b ? wb_data : rt_data;

endmodule

/* decoder.sv */
`timescale 1ns/1ps

module decoder (
    input  pipeline_pkg::word_t     instr,
    input  logic                    valid,
    output pipeline_pkg::reg_addr_t rs_addr,
    output pipeline_pkg::reg_addr_t rt_addr,
    output pipeline_pkg::reg_addr_t dst_addr,
    output pipeline_pkg::word_t     imm,
    output logic [4:0]              shamt,
    output pipeline_pkg::alu_op_e   alu_op,
    output pipeline_pkg::shift_op_e shift_op,
    output pipeline_pkg::res_sel_e  res_sel,
    output logic                    b_is_imm,
    output logic                    shamt_from_reg,
    output logic                    reg_w,
    output logic                    of_w_disable,
    output logic                    movz,
    output logic                    movn
);

    pipeline_pkg::opcode_e  opcode;
    pipeline_pkg::funct_e   funct;
    pipeline_pkg::imm_ext_e imm_ext;
    logic                   supported;

    assign opcode   = pipeline_pkg::opcode_e'(instr[31:26]);
    assign funct    = pipeline_pkg::funct_e'(instr[5:0]);
    assign rs_addr  = instr[25:21];
    assign rt_addr  = instr[20:16];
    assign shamt    = instr[10:6];
    assign dst_addr = (opcode == pipeline_pkg::opc_special) ? instr[15:11] : instr[20:16];

    // Every supported I-type takes the immediate as operand B
    assign b_is_imm = (opcode != pipeline_pkg::opc_special);
    assign shift_op = pipeline_pkg::shift_op_e'(instr[1:0]);
    assign reg_w    = valid && supported;

    always_comb begin
        alu_op         = pipeline_pkg::alu_add;
        res_sel        = pipeline_pkg::res_alu;
        imm_ext        = pipeline_pkg::ext_sign;
        shamt_from_reg = 1'b0;
        of_w_disable   = 1'b0;
        movz           = 1'b0;
        movn           = 1'b0;
        supported      = 1'b1;
        case (opcode)
            pipeline_pkg::opc_special: begin
                case (funct)
                    pipeline_pkg::fn_add:  of_w_disable = 1'b1;
                    pipeline_pkg::fn_addu: alu_op = pipeline_pkg::alu_add;
                    pipeline_pkg::fn_sub: begin
                        alu_op       = pipeline_pkg::alu_sub;
                        of_w_disable = 1'b1;
                    end
                    pipeline_pkg::fn_subu: alu_op = pipeline_pkg::alu_sub;
                    pipeline_pkg::fn_and:  alu_op = pipeline_pkg::alu_and;
                    pipeline_pkg::fn_or:   alu_op = pipeline_pkg::alu_or;
                    pipeline_pkg::fn_xor:  alu_op = pipeline_pkg::alu_xor;
                    pipeline_pkg::fn_nor:  alu_op = pipeline_pkg::alu_nor;
                    pipeline_pkg::fn_slt:  alu_op = pipeline_pkg::alu_slt;
                    pipeline_pkg::fn_sltu: alu_op = pipeline_pkg::alu_sltu;
                    // Bit 2 of the function code picks the variable form
                    pipeline_pkg::fn_sll, pipeline_pkg::fn_srl, pipeline_pkg::fn_sra,
                    pipeline_pkg::fn_sllv, pipeline_pkg::fn_srlv, pipeline_pkg::fn_srav: begin
                        res_sel        = pipeline_pkg::res_shift;
                        shamt_from_reg = instr[2];
                    end
                    pipeline_pkg::fn_movz: movz = 1'b1;
                    pipeline_pkg::fn_movn: movn = 1'b1;
                    default:               supported = 1'b0;
                endcase
            end
            pipeline_pkg::opc_addi:  of_w_disable = 1'b1;
            pipeline_pkg::opc_addiu: alu_op = pipeline_pkg::alu_add;
            pipeline_pkg::opc_slti:  alu_op = pipeline_pkg::alu_slt;
            pipeline_pkg::opc_sltiu: alu_op = pipeline_pkg::alu_sltu;
            pipeline_pkg::opc_andi: begin
                alu_op  = pipeline_pkg::alu_and;
                imm_ext = pipeline_pkg::ext_zero;
            end
            pipeline_pkg::opc_ori: begin
                alu_op  = pipeline_pkg::alu_or;
                imm_ext = pipeline_pkg::ext_zero;
            end
            pipeline_pkg::opc_xori: begin
                alu_op  = pipeline_pkg::alu_xor;
                imm_ext = pipeline_pkg::ext_zero;
            end
            pipeline_pkg::opc_lui: begin
                alu_op  = pipeline_pkg::alu_lui;
                imm_ext = pipeline_pkg::ext_upper;
            end
            default: supported = 1'b0;
        endcase
    end

    // Immediate extension
    always_comb begin
        case (imm_ext)
            pipeline_pkg::ext_zero:  imm = {16'h0000, instr[15:0]};
            pipeline_pkg::ext_upper: imm = {instr[15:0], 16'h0000};
            default:                 imm = {{16{instr[15]}}, instr[15:0]};
        endcase
    end

endmodule

/* gpr.sv */
`timescale 1ns/1ps

module gpr (
    input  logic                    clk,
    input  logic                    reset,
    input  pipeline_pkg::reg_addr_t rs_addr,
    input  pipeline_pkg::reg_addr_t rt_addr,
    output pipeline_pkg::word_t     rs_data,
    output pipeline_pkg::word_t     rt_data,
    input  logic                    w_en,
    input  pipeline_pkg::reg_addr_t w_addr,
    input  pipeline_pkg::word_t     w_data
);

    localparam int num_regs = 2 ** pipeline_pkg::reg_addr_width;

    pipeline_pkg::word_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en && w_addr != '0) begin
            regs[w_addr] <= w_data;
        end
    end

    // $0 reads zero, a write in flight is seen in the same cycle
    function automatic pipeline_pkg::word_t read_port(pipeline_pkg::reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (w_en && w_addr == addr) begin
            return w_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

endmodule

/* pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid_out,
    output payload_t data_out
);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    // Payload follows every edge, only valid_out is qualified
    always_ff @(posedge clk) begin
        data_out <= data_in;
    end

endmodule

/* pipeline_pkg.sv */
package pipeline_pkg;

    localparam int data_width     = 32;
    localparam int reg_addr_width = 5;

    typedef logic [data_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    //////////////////////////////////////////////////////////////////////
    // Instruction encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        opc_special = 6'h00,
        opc_addi    = 6'h08,
        opc_addiu   = 6'h09,
        opc_slti    = 6'h0a,
        opc_sltiu   = 6'h0b,
        opc_andi    = 6'h0c,
        opc_ori     = 6'h0d,
        opc_xori    = 6'h0e,
        opc_lui     = 6'h0f
    } opcode_e;

    // SPECIAL function field
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_sllv = 6'h04,
        fn_srlv = 6'h06,
        fn_srav = 6'h07,
        fn_movz = 6'h0a,
        fn_movn = 6'h0b,
        fn_add  = 6'h20,
        fn_addu = 6'h21,
        fn_sub  = 6'h22,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    //////////////////////////////////////////////////////////////////////
    // Execute controls
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor,
        alu_nor, alu_slt, alu_sltu, alu_lui
    } alu_op_e;

    // Matches the low two bits of the shift function codes
    typedef enum logic [1:0] {
        sh_sll = 2'b00,
        sh_srl = 2'b10,
        sh_sra = 2'b11
    } shift_op_e;

    typedef enum logic {res_alu, res_shift} res_sel_e;

    typedef enum logic [1:0] {ext_sign, ext_zero, ext_upper} imm_ext_e;

    //////////////////////////////////////////////////////////////////////
    // Stage payloads
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t      rs_data;
        word_t      rt_data;
        reg_addr_t  rs_addr;
        reg_addr_t  rt_addr;
        reg_addr_t  dst_addr;
        word_t      imm;
        logic [4:0] shamt;
        alu_op_e    alu_op;
        shift_op_e  shift_op;
        res_sel_e   res_sel;
        logic       b_is_imm;
        logic       shamt_from_reg;
        logic       reg_w;
        logic       of_w_disable;
        logic       movz;
        logic       movn;
    } id_ex_t;

    typedef struct packed {
        reg_addr_t dst_addr;
        word_t     result;
        logic      w_en;
    } ex_wb_t;

endpackage
